//--- source/lsu_defines.svh
//--------------------------------------------------------------------
// Load/store unit sizes
// Data and address width, buffer depth and buffer index width
//--------------------------------------------------------------------

`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// Data and virtual address width
`define XLEN 64

// Number of load/store buffer entries (4, 8 or 16)
`define LSB_DEPTH 4

// Buffer index width, log2 of LSB_DEPTH
`define LSB_IDX_LEN 2

`endif

//--- source/lsu_pkg.sv
//--------------------------------------------------------------------
// Load/store unit types
// Access types, paging modes, exception codes and AGU payloads
//--------------------------------------------------------------------

`include "lsu_defines.svh"

package lsu_pkg;

  // Memory access width and sign extension
  typedef enum logic [2:0] {
    LS_BYTE,
    LS_BYTE_U,
    LS_HALFWORD,
    LS_HALFWORD_U,
    LS_WORD,
    LS_WORD_U,
    LS_DOUBLEWORD
  } ldst_type_t;

  // MODE field of the satp CSR
  typedef enum logic [3:0] {
    BARE = 4'd0,
    SV39 = 4'd8,
    SV48 = 4'd9
  } satp_mode_t;

  // Exception raised by the address adder
  typedef enum logic [1:0] {
    VADDR_NO_EXCEPT,
    VADDR_ALIGN_EXCEPT,
    VADDR_PAGE_EXCEPT
  } vaddr_except_t;

  // Memory operation with ready operands
  typedef struct packed {
    logic             is_store;
    ldst_type_t       ldst_type;
    logic [`XLEN-1:0] base;
    logic [`XLEN-1:0] imm;
  } ldst_op_t;

  // Buffer to adder
  typedef struct packed {
    ldst_op_t                op;
    logic [`LSB_IDX_LEN-1:0] idx;
  } agu_req_t;

  // Adder to buffer, also the retire payload
  typedef struct packed {
    logic [`LSB_IDX_LEN-1:0] idx;
    logic                    is_store;
    logic [`XLEN-1:0]        vaddr;
    vaddr_except_t           except;
  } agu_res_t;

endpackage

//--- source/vaddr_adder.sv
//--------------------------------------------------------------------
// Virtual address adder
// One register stage, then base plus immediate with alignment
// and SV39/SV48 canonical-form checks
//--------------------------------------------------------------------

`timescale 1ns/1ps
`include "lsu_defines.svh"

module vaddr_adder (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  input  lsu_pkg::satp_mode_t  vm_mode_i,
  input  logic                 req_valid_i,
  input  lsu_pkg::agu_req_t    req_i,
  output logic                 res_valid_o,
  output lsu_pkg::agu_res_t    res_o
);
  import lsu_pkg::*;

  agu_req_t         req_q;
  satp_mode_t       mode_q;
  logic             valid_q;
  logic [`XLEN-1:0] vaddr;
  logic             align_fault;
  logic             page_fault;
  vaddr_except_t    except_code;

  //------------------------------------------------------------------
  // Input registers
  //------------------------------------------------------------------

  // Valid bit, dropped on flush so an in-flight result never lands
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req_valid_i;
    end
  end

  // Request payload and paging mode, captured together
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      req_q  <= req_i;
      mode_q <= vm_mode_i;
    end
  end

  //------------------------------------------------------------------
  // Address and exception check
  //------------------------------------------------------------------

  // Wraps at XLEN bits
  assign vaddr = req_q.op.base + req_q.op.imm;

  always_comb begin
    // Natural alignment by access size
    unique case (req_q.op.ldst_type)
      LS_BYTE, LS_BYTE_U:         align_fault = 1'b0;
      LS_HALFWORD, LS_HALFWORD_U: align_fault = vaddr[0];
      LS_WORD, LS_WORD_U:         align_fault = |vaddr[1:0];
      LS_DOUBLEWORD:              align_fault = |vaddr[2:0];
      default:                    align_fault = 1'b0;
    endcase
    // Upper bits must replicate the top translated bit
    unique case (mode_q)
      SV39:    page_fault = vaddr[`XLEN-1:39] != {(`XLEN-39){vaddr[38]}};
      SV48:    page_fault = vaddr[`XLEN-1:48] != {(`XLEN-48){vaddr[47]}};
      default: page_fault = 1'b0;
    endcase
    // Misalignment wins over page fault
    if (align_fault) begin
      except_code = VADDR_ALIGN_EXCEPT;
    end else if (page_fault) begin
      except_code = VADDR_PAGE_EXCEPT;
    end else begin
      except_code = VADDR_NO_EXCEPT;
    end
  end

  // Result back to the buffer entry
  assign res_valid_o = valid_q;

  always_comb begin
    res_o.idx      = req_q.idx;
    res_o.is_store = req_q.op.is_store;
    res_o.vaddr    = vaddr;
    res_o.except   = except_code;
  end

  //------------------------------------------------------------------
  // Assertions
  //------------------------------------------------------------------

  // BARE mode never translates, so never page-faults
  a_bare_no_pfault: assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_valid_o && (mode_q == BARE) |-> res_o.except != VADDR_PAGE_EXCEPT)
    else $error("page fault reported in BARE mode");

  // Flush kills the request that was in the register stage
  a_flush_kills: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |=> !res_valid_o)
    else $error("adder result valid in the cycle after a flush");

endmodule

//--- source/ldst_buffer.sv
//--------------------------------------------------------------------
// Load/store buffer
// Circular in-order buffer: insert, issue to the AGU, result
// write-back, in-order retire and flush
//--------------------------------------------------------------------

`timescale 1ns/1ps
`include "lsu_defines.svh"

module ldst_buffer (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               flush_i,
  input  logic               ins_valid_i,
  input  lsu_pkg::ldst_op_t  ins_op_i,
  output logic               full_o,
  output logic               agu_valid_o,
  output lsu_pkg::agu_req_t  agu_req_o,
  input  logic               agu_res_valid_i,
  input  lsu_pkg::agu_res_t  agu_res_i,
  output logic               done_valid_o,
  output lsu_pkg::agu_res_t  done_res_o,
  input  logic               done_ready_i
);
  import lsu_pkg::*;

  // Per-entry state flags
  logic [`LSB_DEPTH-1:0]   valid_q;
  logic [`LSB_DEPTH-1:0]   issued_q;
  logic [`LSB_DEPTH-1:0]   done_q;
  // Entry payloads
  ldst_op_t                op_q [`LSB_DEPTH];
  agu_res_t                res_q [`LSB_DEPTH];
  // Pointers and occupancy
  logic [`LSB_IDX_LEN-1:0] head_q;
  logic [`LSB_IDX_LEN-1:0] tail_q;
  logic [`LSB_IDX_LEN:0]   count_q;
  // Handshakes
  logic                    ins_fire;
  logic                    ret_fire;
  logic                    issue_found;
  logic [`LSB_IDX_LEN-1:0] issue_idx;

  assign full_o   = count_q == (`LSB_IDX_LEN+1)'(`LSB_DEPTH);
  assign ins_fire = ins_valid_i && !full_o;

  //------------------------------------------------------------------
  // Issue selection
  //------------------------------------------------------------------

  // Oldest valid entry not yet sent, scanning from the head
  always_comb begin : issue_select
    logic [`LSB_IDX_LEN-1:0] idx;
    issue_found = 1'b0;
    issue_idx   = head_q;
    for (int i = 0; i < `LSB_DEPTH; i++) begin
      idx = head_q + i[`LSB_IDX_LEN-1:0];
      if (!issue_found && valid_q[idx] && !issued_q[idx]) begin
        issue_found = 1'b1;
        issue_idx   = idx;
      end
    end
  end

  assign agu_valid_o = issue_found;

  always_comb begin
    agu_req_o.op  = op_q[issue_idx];
    agu_req_o.idx = issue_idx;
  end

  //------------------------------------------------------------------
  // Retire port
  //------------------------------------------------------------------

  // Head leaves only when its address is known
  assign done_valid_o = valid_q[head_q] && done_q[head_q];
  assign done_res_o   = res_q[head_q];
  assign ret_fire     = done_valid_o && done_ready_i;

  //------------------------------------------------------------------
  // Control state
  //------------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      issued_q <= '0;
      done_q   <= '0;
      head_q   <= '0;
      tail_q   <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      valid_q  <= '0;
      issued_q <= '0;
      done_q   <= '0;
      head_q   <= '0;
      tail_q   <= '0;
      count_q  <= '0;
    end else begin
      // New entry at the tail
      if (ins_fire) begin
        valid_q[tail_q]  <= 1'b1;
        issued_q[tail_q] <= 1'b0;
        done_q[tail_q]   <= 1'b0;
        tail_q           <= tail_q + 1'b1;
      end
      // Sent to the adder this cycle
      if (issue_found) begin
        issued_q[issue_idx] <= 1'b1;
      end
      // Adder result returned
      if (agu_res_valid_i) begin
        done_q[agu_res_i.idx] <= 1'b1;
      end
      // Head accepted downstream
      if (ret_fire) begin
        valid_q[head_q] <= 1'b0;
        head_q          <= head_q + 1'b1;
      end
      unique case ({ins_fire, ret_fire})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Payload storage
  always_ff @(posedge clk_i) begin
    if (ins_fire) begin
      op_q[tail_q] <= ins_op_i;
    end
    if (agu_res_valid_i) begin
      res_q[agu_res_i.idx] <= agu_res_i;
    end
  end

  //------------------------------------------------------------------
  // Assertions
  //------------------------------------------------------------------

  // Producer must respect full
  a_no_ins_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ins_valid_i |-> !full_o)
    else $error("insert attempted while buffer full");

  // Write-back lands on a live entry waiting for its address
  a_wb_target: assert property (@(posedge clk_i) disable iff (!rst_ni)
    agu_res_valid_i |-> valid_q[agu_res_i.idx] && issued_q[agu_res_i.idx]
                        && !done_q[agu_res_i.idx])
    else $error("write-back to entry %0d in wrong state", agu_res_i.idx);

endmodule

//--- source/ldst_agu_top.sv
//--------------------------------------------------------------------
// Load/store address generation top level
// Load/store buffer feeding the one-stage virtual address adder
//--------------------------------------------------------------------

`timescale 1ns/1ps

module ldst_agu_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  input  lsu_pkg::satp_mode_t  vm_mode_i,
  input  logic                 ins_valid_i,
  input  lsu_pkg::ldst_op_t    ins_op_i,
  output logic                 full_o,
  output logic                 done_valid_o,
  output lsu_pkg::agu_res_t    done_res_o,
  input  logic                 done_ready_i
);
  import lsu_pkg::*;

  // Issue path, buffer to adder
  logic     agu_valid;
  agu_req_t agu_req;
  // Write-back path, adder to buffer
  logic     agu_res_valid;
  agu_res_t agu_res;

  ldst_buffer ldst_buffer_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .ins_valid_i     (ins_valid_i),
    .ins_op_i        (ins_op_i),
    .full_o          (full_o),
    .agu_valid_o     (agu_valid),
    .agu_req_o       (agu_req),
    .agu_res_valid_i (agu_res_valid),
    .agu_res_i       (agu_res),
    .done_valid_o    (done_valid_o),
    .done_res_o      (done_res_o),
    .done_ready_i    (done_ready_i)
  );

  // Always takes a request, the buffer holds a slot for every result
  vaddr_adder vaddr_adder_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .vm_mode_i   (vm_mode_i),
    .req_valid_i (agu_valid),
    .req_i       (agu_req),
    .res_valid_o (agu_res_valid),
    .res_o       (agu_res)
  );

endmodule

//--- verification/tb_ldst_agu.sv
//----------------------------------------------------------------------
// Load/store AGU testbench
// Random load/store traffic checked against a reference adder model,
// with in-order retire, back-pressure and flush
//----------------------------------------------------------------------

`timescale 1ns/1ps
`include "lsu_defines.svh"

module tb_ldst_agu;
  import lsu_pkg::*;

  // About 1200 operations finish well under 5000 cycles, four times that
  localparam int TIMEOUT_CYCLES = 20000;
  // A full buffer retires in a few cycles per entry with ready held high
  localparam int DRAIN_CYCLES = 4 * `LSB_DEPTH + 8;

  logic       clk_i;
  logic       rst_ni;
  logic       flush_i;
  satp_mode_t vm_mode_i;
  logic       ins_valid_i;
  ldst_op_t   ins_op_i;
  logic       full_o;
  logic       done_valid_o;
  agu_res_t   done_res_o;
  logic       done_ready_i;

  // Model of the buffer contents, in insertion order
  agu_res_t                exp_q[$];
  logic [`LSB_IDX_LEN-1:0] tail_idx;
  int                      occupancy;
  int                      ready_pct;
  logic                    flush_seen;
  logic                    saw_full;
  string                   test_name;
  integer                  seed;
  int                      cycle_cnt;
  int                      accepted;
  int                      retired;

  ldst_agu_top ldst_agu_top_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .vm_mode_i    (vm_mode_i),
    .ins_valid_i  (ins_valid_i),
    .ins_op_i     (ins_op_i),
    .full_o       (full_o),
    .done_valid_o (done_valid_o),
    .done_res_o   (done_res_o),
    .done_ready_i (done_ready_i)
  );

  // 20 ns clock
  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  //--------------------------------------------------------------------
  // Reference model and random helpers
  //--------------------------------------------------------------------

  function automatic agu_res_t expected_result(ldst_op_t op, satp_mode_t mode,
                                               logic [`LSB_IDX_LEN-1:0] idx);
    agu_res_t         res;
    logic [`XLEN-1:0] top;
    logic [`XLEN-1:0] size;
    logic             noncanon;
    res.idx      = idx;
    res.is_store = op.is_store;
    res.vaddr    = op.base + op.imm;
    // Access size in bytes
    case (op.ldst_type)
      LS_HALFWORD, LS_HALFWORD_U: size = 2;
      LS_WORD, LS_WORD_U:         size = 4;
      LS_DOUBLEWORD:              size = 8;
      default:                    size = 1;
    endcase
    // From the top translated bit upward: all zeros or all ones
    noncanon = 1'b0;
    if (mode == SV39) begin
      top      = res.vaddr >> 38;
      noncanon = top != 0 && top != (64'd1 << 26) - 1;
    end else if (mode == SV48) begin
      top      = res.vaddr >> 47;
      noncanon = top != 0 && top != (64'd1 << 17) - 1;
    end
    if (res.vaddr % size != 0)
      res.except = VADDR_ALIGN_EXCEPT;
    else if (noncanon)
      res.except = VADDR_PAGE_EXCEPT;
    else
      res.except = VADDR_NO_EXCEPT;
    return res;
  endfunction

  function automatic int unsigned rand_below(int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic logic [`XLEN-1:0] rand_word();
    return {$random(seed), $random(seed)};
  endfunction

  // Sign extension from bit 36..49, one bit flipped now and then
  function automatic logic [`XLEN-1:0] near_boundary_addr();
    int unsigned      pos;
    logic [`XLEN-1:0] addr;
    pos  = 36 + rand_below(14);
    addr = rand_word() & ((64'd1 << pos) - 1);
    if (rand_below(2) == 0)
      addr = addr | (~64'd0 << pos);
    if (rand_below(4) == 0)
      addr = addr ^ (64'd1 << (36 + rand_below(28)));
    return addr;
  endfunction

  function automatic ldst_op_t make_op(int kind, int i);
    ldst_op_t op;
    op.is_store  = rand_below(2) == 1;
    op.ldst_type = ldst_type_t'(3'(rand_below(7)));
    op.base      = rand_word();
    op.imm       = rand_word();
    case (kind)
      // Both operands 8-byte aligned, sum may wrap
      0: begin
        op.base[2:0] = 3'b000;
        op.imm[2:0]  = 3'b000;
      end
      // Each access type in turn, small signed offsets
      1: begin
        op.ldst_type = ldst_type_t'(3'(i % 7));
        op.imm       = 64'(rand_below(64)) - 64'd32;
      end
      2: op.base = near_boundary_addr() - op.imm;
      default: ;
    endcase
    return op;
  endfunction

  //--------------------------------------------------------------------
  // Driver
  //--------------------------------------------------------------------

  // Account the handshakes seen just before this edge
  task automatic clock_edge();
    @(posedge clk_i);
    if (flush_seen) begin
      assert (!done_valid_o)
      else begin
        $display("done_valid_o high in the cycle after a flush, test %s", test_name);
        end_in_failure();
      end
    end
    flush_seen = flush_i;
    saw_full   = saw_full | full_o;
    if (flush_i) begin
      exp_q.delete();
      tail_idx  = '0;
      occupancy = 0;
    end else begin
      if (ins_valid_i && !full_o) begin
        exp_q.push_back(expected_result(ins_op_i, vm_mode_i, tail_idx));
        tail_idx  = tail_idx + 1'b1;
        occupancy = occupancy + 1;
        accepted  = accepted + 1;
      end
      if (done_valid_o && done_ready_i)
        occupancy = occupancy - 1;
    end
  endtask

  // Insert only when the buffer has room after this edge
  task automatic drive_cycle(input logic want_ins, input ldst_op_t op, output logic sent);
    clock_edge();
    sent = want_ins && occupancy < `LSB_DEPTH;
    ins_valid_i  <= sent;
    ins_op_i     <= op;
    flush_i      <= 1'b0;
    done_ready_i <= rand_below(100) < ready_pct;
  endtask

  task automatic run_ops(input string name, input int n, input int kind, input int pct);
    ldst_op_t op;
    logic     sent;
    test_name = name;
    ready_pct = pct;
    for (int i = 0; i < n; i++) begin
      op   = make_op(kind, i);
      sent = 1'b0;
      while (!sent)
        drive_cycle(1'b1, op, sent);
    end
  endtask

  // Retire everything within a bounded wait, one spare cycle for the compare process
  task automatic drain();
    logic sent;
    int   waited;
    ready_pct = 100;
    waited    = 0;
    while (occupancy != 0 && waited < DRAIN_CYCLES) begin
      drive_cycle(1'b0, '0, sent);
      waited = waited + 1;
    end
    drive_cycle(1'b0, '0, sent);
  endtask

  // Paging mode changes only with the buffer empty
  task automatic set_mode(input satp_mode_t mode);
    drain();
    vm_mode_i <= mode;
  endtask

  task automatic flush_now();
    clock_edge();
    ins_valid_i  <= 1'b0;
    done_ready_i <= 1'b0;
    flush_i      <= 1'b1;
  endtask

  task automatic end_in_failure();
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  //--------------------------------------------------------------------
  // Compare and timeout
  //--------------------------------------------------------------------

  always @(posedge clk_i) begin : compare
    agu_res_t want;
    if (rst_ni && !flush_i && done_valid_o && done_ready_i) begin
      assert (exp_q.size() != 0)
      else begin
        $display("Retire handshake with no operation expected, test %s", test_name);
        end_in_failure();
      end
      want = exp_q.pop_front();
      assert (done_res_o === want)
      else begin
        $display("ERR %s: expected idx %0d store %0b vaddr %h except %0d, ",
                 test_name, want.idx, want.is_store, want.vaddr, want.except,
                 "actual idx %0d store %0b vaddr %h except %0d", done_res_o.idx,
                 done_res_o.is_store, done_res_o.vaddr, done_res_o.except);
        end_in_failure();
      end
      retired = retired + 1;
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles in test %s", cycle_cnt, test_name);
      end_in_failure();
    end
  end

  //--------------------------------------------------------------------
  // Test sequence
  //--------------------------------------------------------------------

  initial begin : main
    logic sent;
    int   acc0;
    int   ret0;
    seed         = 83104;
    rst_ni       = 1'b0;
    flush_i      = 1'b0;
    vm_mode_i    = BARE;
    ins_valid_i  = 1'b0;
    ins_op_i     = '0;
    done_ready_i = 1'b0;
    tail_idx     = '0;
    occupancy    = 0;
    ready_pct    = 100;
    flush_seen   = 1'b0;
    saw_full     = 1'b0;
    cycle_cnt    = 0;
    accepted     = 0;
    retired      = 0;
    test_name    = "reset";
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    drain();
    assert (!done_valid_o && !full_o)
    else begin
      $display("done_valid_o or full_o high after reset");
      end_in_failure();
    end
    // Plain sums in BARE mode, then alignment per access type
    run_ops("addr_sum", 250, 0, 80);
    run_ops("align", 250, 1, 80);
    // Canonical-form checks in each paging mode
    set_mode(SV39);
    run_ops("page_sv39", 100, 2, 80);
    set_mode(SV48);
    run_ops("page_sv48", 100, 2, 80);
    set_mode(BARE);
    run_ops("page_bare", 100, 2, 80);
    // Heavy back-pressure, buffer must fill
    drain();
    saw_full = 1'b0;
    acc0     = accepted;
    ret0     = retired;
    run_ops("order", 300, 3, 30);
    drain();
    assert (saw_full && accepted - acc0 == 300 && retired - ret0 == 300)
    else begin
      $display("Order test: full_o never seen or %0d inserted, %0d retired",
               accepted - acc0, retired - ret0);
      end_in_failure();
    end
    // Flush with work in flight, then normal traffic
    for (int r = 0; r < 12; r++) begin
      run_ops("flush", 2 + rand_below(5), 3, 50);
      repeat (rand_below(3)) drive_cycle(1'b0, '0, sent);
      flush_now();
    end
    run_ops("after_flush", 40, 3, 50);
    drain();
    if (exp_q.size() != 0) begin
      $display("%0d operations were never retired", exp_q.size());
      end_in_failure();
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

//--- flist.f
+incdir+source
source/lsu_pkg.sv
source/vaddr_adder.sv
source/ldst_buffer.sv
source/ldst_agu_top.sv
verification/tb_ldst_agu.sv
